// ==== ts_match_replace.f ====
+incdir+verilog
verilog/ts_filter_pkg.sv
verilog/pid_match_if.sv
verilog/ts_byte_counter.sv
verilog/ts_packet_fsm.sv
verilog/ts_header_delay.sv
verilog/pid_slot_table.sv
verilog/replace_packet_ram.sv
verilog/ts_match_replace.sv
tests/tb_ts_match_replace.sv

// ==== Bender.yml ====
package:
  name: ts_match_replace

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ts_filter_pkg.sv
      - verilog/pid_match_if.sv
      - verilog/ts_byte_counter.sv
      - verilog/ts_packet_fsm.sv
      - verilog/ts_header_delay.sv
      - verilog/pid_slot_table.sv
      - verilog/replace_packet_ram.sv
      - verilog/ts_match_replace.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_ts_match_replace.sv

// ==== tests/tb_ts_match_replace.sv ====
`timescale 1ns/10ps
`include "ts_filter_defines.svh"

module tb_ts_match_replace;

  localparam int N_ENTRIES = 15;

  logic axi_clk;
  logic rst;
  logic [7:0] mpeg_data;
  logic mpeg_valid;
  logic mpeg_sync;
  logic axi_wren;
  logic replace_add;
  logic replace_del;
  logic monitor_add;
  logic monitor_del;
  logic [12:0] pid_in;
  logic [7:0] slot_idx;
  logic ts_valid;
  logic ts_sync;
  logic [7:0] ts_out;
  logic dump_valid;
  logic [`TS_FILTER_SLOTS-1:0] dump_flag;
  logic [7:0] dump_data;

  // each entry holds action, slot, pid, replaced flag, replace slot and dump mask
  logic [39:0] stim [N_ENTRIES];
  logic [7:0] rep_mem [`TS_FILTER_SLOTS][`TS_PACKET_BYTES];
  logic [7:0] pkt [`TS_PACKET_BYTES];
  logic [24:0] exp_q [$]; // {mask, sync, live byte, output byte}
  logic [24:0] exp_w;
  integer seed;
  int err_count;
  int pass_count;
  int fail_count;
  int errs_before;
  bit timed_out;

  ts_match_replace UUT (.*);

  always #10 axi_clk = ~axi_clk;

  task automatic cfg_write(input logic add, input logic rdel, input logic madd,
                           input logic mdel, input logic [7:0] slot, input logic [12:0] pid);
    @(posedge axi_clk);
    #2;
    axi_wren = 1'b1;
    replace_add = add;
    replace_del = rdel;
    monitor_add = madd;
    monitor_del = mdel;
    slot_idx = slot;
    pid_in = pid;
  endtask

  task automatic cfg_idle();
    @(posedge axi_clk);
    #2;
    {axi_wren, replace_add, replace_del, monitor_add, monitor_del} = '0;
  endtask

  task automatic load_replacement(input logic [2:0] slot, input logic [12:0] pid);
    rep_mem[slot][0] = `TS_SYNC_BYTE;
    rep_mem[slot][1] = {3'b000, pid[12:8]};
    rep_mem[slot][2] = pid[7:0];
    rep_mem[slot][3] = 8'h10;
    for (int p = `TS_HEADER_BYTES; p < `TS_PACKET_BYTES; p++) rep_mem[slot][p] = $random(seed);
    cfg_write(1'b1, 1'b0, 1'b0, 1'b0, {5'b0, slot}, 13'h0); // names the slot
    for (int p = 0; p < `TS_PACKET_BYTES; p++) begin
      cfg_write(1'b1, 1'b0, 1'b0, 1'b0, {5'b0, slot}, {5'b0, rep_mem[slot][p]});
    end
    cfg_idle();
  endtask

  task automatic send_beat(input logic [7:0] data, input logic sync);
    @(posedge axi_clk);
    #2;
    mpeg_valid = 1'b1;
    mpeg_sync = sync;
    mpeg_data = data;
  endtask

  task automatic stream_packet(input logic [12:0] pid, input logic [3:0] cc,
                               input logic replaced, input logic [2:0] rslot,
                               input logic [7:0] mask);
    logic [31:0] r;
    pkt[0] = `TS_SYNC_BYTE;
    pkt[1] = {3'b010, pid[12:8]};
    pkt[2] = pid[7:0];
    pkt[3] = {4'h1, cc};
    for (int p = `TS_HEADER_BYTES; p < `TS_PACKET_BYTES; p++) pkt[p] = $random(seed);
    for (int p = 0; p < `TS_PACKET_BYTES; p++) begin
      exp_q.push_back({mask, p == 0, pkt[p], replaced ? rep_mem[rslot][p] : pkt[p]});
    end
    for (int p = 0; p < `TS_PACKET_BYTES; p++) begin
      r = $random(seed);
      if (r[1:0] == 2'b00) begin // idle gap of 1 to 4 cycles
        @(posedge axi_clk);
        #2;
        mpeg_valid = 1'b0;
        mpeg_sync = 1'b0;
        repeat (r[3:2]) @(posedge axi_clk);
      end
      send_beat(pkt[p], p == 0);
    end
    @(posedge axi_clk);
    #2;
    mpeg_valid = 1'b0;
    mpeg_sync = 1'b0;
  endtask

  task automatic drain(input int target);
    int cnt;
    cnt = 0;
    while (exp_q.size() > target && cnt < 2000) begin
      @(negedge axi_clk);
      cnt++;
    end
    if (exp_q.size() > target) begin
      $display("output stopped at %0t with %0d bytes still expected", $time, exp_q.size());
      timed_out = 1'b1;
    end
  endtask

  always @(negedge axi_clk) begin
    if (!rst) begin
      if (ts_valid) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("Fail %0t: output byte %h with nothing expected", $time, ts_out);
        end else begin
          exp_w = exp_q.pop_front();
          if (ts_out !== exp_w[7:0]) begin
            err_count++;
            $display("Fail %0t: ts_out %h, expected %h", $time, ts_out, exp_w[7:0]);
          end
          if (ts_sync !== exp_w[16]) begin
            err_count++;
            $display("Fail %0t: ts_sync %b, expected %b", $time, ts_sync, exp_w[16]);
          end
          if (dump_valid !== (exp_w[24:17] != 0) || dump_flag !== exp_w[24:17]) begin
            err_count++;
            $display("Fail %0t: dump_valid %b dump_flag %h, expected mask %h",
                     $time, dump_valid, dump_flag, exp_w[24:17]);
          end
          if (dump_valid && dump_data !== exp_w[15:8]) begin
            err_count++;
            $display("Fail %0t: dump_data %h, expected %h", $time, dump_data, exp_w[15:8]);
          end
        end
      end else if (ts_sync || dump_valid) begin
        err_count++;
        $display("Fail %0t: ts_sync or dump_valid high without ts_valid", $time);
      end
    end
  end

  initial begin
    seed = 32'hdde5e4fc;
    {axi_clk, mpeg_data, mpeg_valid, mpeg_sync, pid_in, slot_idx} = '0;
    {axi_wren, replace_add, replace_del, monitor_add, monitor_del} = '0;
    rst = 1'b1;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    timed_out = 1'b0;
    // action codes 0 none, 1 load, 2 replace del, 3 monitor add, 4 monitor del
    stim[0] = 40'h0_0_0100_0_0_00;
    stim[1] = 40'h0_0_1abc_0_0_00;
    stim[2] = 40'h1_2_0100_1_2_00;
    stim[3] = 40'h0_0_0200_0_0_00;
    stim[4] = 40'h3_1_0200_0_0_02;
    stim[5] = 40'h3_6_0100_1_2_40; // replaced and dumped
    stim[6] = 40'h1_5_0100_1_2_40; // lower slot still wins
    stim[7] = 40'h2_2_0100_1_5_40;
    stim[8] = 40'h4_6_0100_1_5_00;
    stim[9] = 40'h2_5_0100_0_0_00;
    stim[10] = 40'h4_1_0200_0_0_00;
    stim[11] = 40'h1_0_1abc_1_0_00;
    stim[12] = 40'h3_7_1abc_1_0_80;
    stim[13] = 40'h3_3_1abc_1_0_88;
    stim[14] = 40'h0_0_0055_0_0_00;
    repeat (5) @(posedge axi_clk);
    #2;
    rst = 1'b0;

    for (int i = 0; i < N_ENTRIES && !timed_out; i++) begin
      errs_before = err_count;
      case (stim[i][39:36])
        4'd1: load_replacement(stim[i][34:32], stim[i][28:16]);
        4'd2: cfg_write(1'b0, 1'b1, 1'b0, 1'b0, {5'b0, stim[i][34:32]}, 13'h0);
        4'd3: cfg_write(1'b0, 1'b0, 1'b1, 1'b0, {5'b0, stim[i][34:32]}, stim[i][28:16]);
        4'd4: cfg_write(1'b0, 1'b0, 1'b0, 1'b1, {5'b0, stim[i][34:32]}, 13'h0);
        default: ;
      endcase
      if (stim[i][39:36] > 4'd1) cfg_idle();
      stream_packet(stim[i][28:16], i[3:0], stim[i][12], stim[i][10:8], stim[i][7:0]);
      if (i == N_ENTRIES - 1) begin
        // push the last four bytes out of the delay line
        for (int f = 0; f < `TS_HEADER_BYTES; f++) send_beat(8'h00, 1'b0);
        @(posedge axi_clk);
        #2;
        mpeg_valid = 1'b0;
        drain(0);
      end else begin
        drain(`TS_HEADER_BYTES);
      end
      if (err_count == errs_before && !timed_out) begin
        pass_count++;
        $display("entry %0d pid %h passed", i, stim[i][28:16]);
      end else begin
        fail_count++;
        $display("entry %0d pid %h failed with %0d mismatches", i, stim[i][28:16],
                 err_count - errs_before);
      end
    end
    repeat (5) @(posedge axi_clk);

    $display("%0d entries passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verilog/ts_match_replace.sv ====
`timescale 1ns/10ps
`include "ts_filter_defines.svh"

module ts_match_replace
  import ts_filter_pkg::*;
(
  input logic axi_clk,
  input logic rst,
  input logic [7:0] mpeg_data,
  input logic mpeg_valid,
  input logic mpeg_sync,
  input logic axi_wren,
  input logic replace_add,
  input logic replace_del,
  input logic monitor_add,
  input logic monitor_del,
  input logic [12:0] pid_in,
  input logic [7:0] slot_idx,
  output logic ts_valid,
  output logic ts_sync,
  output logic [7:0] ts_out,
  output logic dump_valid,
  output logic [`TS_FILTER_SLOTS-1:0] dump_flag,
  output logic [7:0] dump_data
);

  localparam logic [`TS_POS_W-1:0] HDR_LEN = `TS_HEADER_BYTES;
  localparam logic [`TS_POS_W-1:0] WRAP_ADD = `TS_PACKET_BYTES - `TS_HEADER_BYTES;

  logic [`TS_POS_W-1:0] pos;
  logic [`TS_POS_W-1:0] out_pos;
  ts_header_t header;
  logic [7:0] live_byte;
  logic [7:0] rd_data;
  logic out_replace;
  logic [`TS_FILTER_SLOTS-1:0] out_monitor_mask;
  logic [`TS_SLOT_W-1:0] out_slot;
  logic stream_live;
  logic commit;
  logic [`TS_SLOT_W-1:0] commit_slot;
  logic [12:0] commit_pid;
  logic emit;

  pid_match_if match_bus ();

  ts_byte_counter u_counter (
    .axi_clk (axi_clk),
    .rst     (rst),
    .advance (mpeg_valid),
    .restart (mpeg_valid && mpeg_sync),
    .pos     (pos),
    .last    ()
  );

  ts_header_delay u_delay (
    .axi_clk (axi_clk),
    .rst     (rst),
    .shift   (mpeg_valid),
    .din     (mpeg_data),
    .dout    (live_byte),
    .header  (header)
  );

  ts_packet_fsm u_fsm (
    .axi_clk          (axi_clk),
    .rst              (rst),
    .mpeg_valid       (mpeg_valid),
    .mpeg_sync        (mpeg_sync),
    .pos              (pos),
    .header           (header),
    .match            (match_bus.fsm),
    .out_replace      (out_replace),
    .out_monitor_mask (out_monitor_mask),
    .out_slot         (out_slot),
    .stream_live      (stream_live)
  );

  pid_slot_table u_table (
    .axi_clk     (axi_clk),
    .rst         (rst),
    .axi_wren    (axi_wren),
    .replace_del (replace_del),
    .monitor_add (monitor_add),
    .monitor_del (monitor_del),
    .slot_idx    (slot_idx),
    .pid_in      (pid_in),
    .commit      (commit),
    .commit_slot (commit_slot),
    .commit_pid  (commit_pid),
    .match       (match_bus.tbl)
  );

  replace_packet_ram u_ram (
    .axi_clk     (axi_clk),
    .rst         (rst),
    .axi_wren    (axi_wren),
    .replace_add (replace_add),
    .slot_idx    (slot_idx),
    .pid_in      (pid_in),
    .rd_slot     (out_slot),
    .rd_pos      (out_pos),
    .rd_data     (rd_data),
    .commit      (commit),
    .commit_slot (commit_slot),
    .commit_pid  (commit_pid)
  );

  // packet position of the byte leaving the delay line
  assign out_pos = (pos >= HDR_LEN) ? pos - HDR_LEN : pos + WRAP_ADD;
  assign emit = mpeg_valid && stream_live;

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      ts_valid <= 1'b0;
      ts_sync <= 1'b0;
      dump_valid <= 1'b0;
      dump_flag <= '0;
    end else begin
      ts_valid <= emit;
      ts_sync <= emit && out_pos == '0;
      dump_valid <= emit && |out_monitor_mask;
      if (emit) dump_flag <= out_monitor_mask; // lines up with byte 0
    end
  end

  always_ff @(posedge axi_clk) begin
    if (emit) begin
      ts_out <= out_replace ? rd_data : live_byte;
      dump_data <= live_byte; // dump always sees the live stream
    end
  end

endmodule

// ==== verilog/replace_packet_ram.sv ====
`timescale 1ns/10ps
`include "ts_filter_defines.svh"

module replace_packet_ram
  import ts_filter_pkg::*;
(
  input logic axi_clk,
  input logic rst,
  input logic axi_wren,
  input logic replace_add,
  input logic [7:0] slot_idx,
  input logic [12:0] pid_in,
  input logic [`TS_SLOT_W-1:0] rd_slot,
  input logic [`TS_POS_W-1:0] rd_pos,
  output logic [7:0] rd_data,
  output logic commit,
  output logic [`TS_SLOT_W-1:0] commit_slot,
  output logic [12:0] commit_pid
);

  logic [7:0] mem [`TS_FILTER_SLOTS][`TS_PACKET_BYTES];
  logic loading;
  logic [`TS_SLOT_W-1:0] load_slot;
  logic [`TS_POS_W-1:0] cursor;
  logic wr;
  ts_header_t stored_hdr;

  assign wr = axi_wren && replace_add;

  // strobe on the write of the last byte
  assign commit = wr && loading && cursor == `TS_PACKET_BYTES - 1;
  assign commit_slot = load_slot;

  assign stored_hdr.bytes = {mem[load_slot][0], mem[load_slot][1],
                             mem[load_slot][2], mem[load_slot][3]};
  assign commit_pid = stored_hdr.fields.pid;

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      loading <= 1'b0;
      load_slot <= '0;
      cursor <= '0;
    end else if (wr) begin
      if (!loading) begin
        // first write only names the slot
        if (slot_idx < `TS_FILTER_SLOTS) begin
          loading <= 1'b1;
          load_slot <= slot_idx[`TS_SLOT_W-1:0];
          cursor <= '0;
        end
      end else begin
        if (commit) loading <= 1'b0;
        cursor <= cursor + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (wr && loading) mem[load_slot][cursor] <= pid_in[7:0];
  end

  assign rd_data = mem[rd_slot][rd_pos];

endmodule

// ==== verilog/pid_slot_table.sv ====
`timescale 1ns/10ps
`include "ts_filter_defines.svh"

module pid_slot_table (
  input logic axi_clk,
  input logic rst,
  input logic axi_wren,
  input logic replace_del,
  input logic monitor_add,
  input logic monitor_del,
  input logic [7:0] slot_idx,
  input logic [12:0] pid_in,
  input logic commit,
  input logic [`TS_SLOT_W-1:0] commit_slot,
  input logic [12:0] commit_pid,
  pid_match_if.tbl match
);

  logic [`TS_FILTER_SLOTS-1:0] rep_valid;
  logic [`TS_FILTER_SLOTS-1:0] mon_valid;
  logic [12:0] rep_pid [`TS_FILTER_SLOTS];
  logic [12:0] mon_pid [`TS_FILTER_SLOTS];
  logic [`TS_SLOT_W-1:0] idx;
  logic cfg_ok;
  logic hit;
  logic [`TS_SLOT_W-1:0] hit_slot;
  logic [`TS_FILTER_SLOTS-1:0] mon_hit;

  assign idx = slot_idx[`TS_SLOT_W-1:0];
  assign cfg_ok = axi_wren && slot_idx < `TS_FILTER_SLOTS; // out of range ignored

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      rep_valid <= '0;
      mon_valid <= '0;
    end else begin
      if (commit) rep_valid[commit_slot] <= 1'b1;
      if (cfg_ok) begin
        if (replace_del) rep_valid[idx] <= 1'b0;
        else if (monitor_add) mon_valid[idx] <= 1'b1;
        else if (monitor_del) mon_valid[idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (commit) rep_pid[commit_slot] <= commit_pid;
    if (cfg_ok && !replace_del && monitor_add) mon_pid[idx] <= pid_in;
  end

  // scan downwards so the lowest matching slot is kept
  always_comb begin
    hit = 1'b0;
    hit_slot = '0;
    for (int i = `TS_FILTER_SLOTS - 1; i >= 0; i--) begin
      if (rep_valid[i] && rep_pid[i] == match.live_pid) begin
        hit = 1'b1;
        hit_slot = `TS_SLOT_W'(i);
      end
      mon_hit[i] = mon_valid[i] && mon_pid[i] == match.live_pid;
    end
  end

  assign match.replace_hit = match.lookup && hit;
  assign match.replace_slot = hit_slot;
  assign match.monitor_mask = match.lookup ? mon_hit : '0;

  // a load finishing and a delete of that slot must not collide
  a_commit_vs_del: assert property (
    @(posedge axi_clk) disable iff (rst)
    commit && cfg_ok && replace_del |-> commit_slot != idx
  );

endmodule

// ==== verilog/ts_header_delay.sv ====
`timescale 1ns/10ps
`include "ts_filter_defines.svh"

module ts_header_delay
  import ts_filter_pkg::*;
(
  input logic axi_clk,
  input logic rst,
  input logic shift,
  input logic [7:0] din,
  output logic [7:0] dout,
  output ts_header_t header
);

  // stage[0] is the oldest byte
  logic [0:`TS_HEADER_BYTES-1][7:0] stage;

  // three stored bytes plus the incoming one
  assign header.bytes = {stage[1:`TS_HEADER_BYTES-1], din};

  assign dout = stage[0]; // byte from four beats back

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      stage <= '0;
    end else if (shift) begin
      stage <= header.bytes;
    end
  end

endmodule

// ==== verilog/ts_packet_fsm.sv ====
`timescale 1ns/10ps
`include "ts_filter_defines.svh"

module ts_packet_fsm
  import ts_filter_pkg::*;
(
  input logic axi_clk,
  input logic rst,
  input logic mpeg_valid,
  input logic mpeg_sync,
  input logic [`TS_POS_W-1:0] pos,
  input ts_header_t header,
  pid_match_if.fsm match,
  output logic out_replace,
  output logic [`TS_FILTER_SLOTS-1:0] out_monitor_mask,
  output logic [`TS_SLOT_W-1:0] out_slot,
  output logic stream_live
);

  localparam logic [1:0] HUNT = 2'd0;
  localparam logic [1:0] HEADER = 2'd1;
  localparam logic [1:0] STREAM = 2'd2;

  logic [1:0] state;
  logic hdr_beat;

  // beat carrying header byte 3
  assign hdr_beat = mpeg_valid && state == HEADER && pos == `TS_HEADER_BYTES - 1;

  // skip the lookup if the header did not start with a sync byte
  assign match.lookup = hdr_beat && header.fields.sync == `TS_SYNC_BYTE;
  assign match.live_pid = header.fields.pid;

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      state <= HUNT;
      out_replace <= 1'b0;
      out_monitor_mask <= '0;
      out_slot <= '0;
      stream_live <= 1'b0;
    end else begin
      if (mpeg_valid && mpeg_sync) begin
        state <= HEADER;
      end else if (hdr_beat) begin
        state <= match.lookup ? STREAM : HUNT;
      end else if (mpeg_valid && state == STREAM && pos == '0) begin
        state <= HEADER; // counter wrapped into the next packet
      end

      // mode for the packet about to leave the delay line
      if (match.lookup) begin
        out_replace <= match.replace_hit;
        out_slot <= match.replace_slot;
        out_monitor_mask <= match.monitor_mask;
        stream_live <= 1'b1;
      end else if (hdr_beat) begin
        out_replace <= 1'b0;
        out_monitor_mask <= '0;
      end
    end
  end

  // the registered packet mode must come from a known table answer
  a_lookup_answer_known: assert property (
    @(posedge axi_clk) disable iff (rst)
    match.lookup |-> !$isunknown({match.replace_hit, match.replace_slot, match.monitor_mask})
  );

endmodule

// ==== verilog/ts_byte_counter.sv ====
`timescale 1ns/10ps
`include "ts_filter_defines.svh"

module ts_byte_counter (
  input logic axi_clk,
  input logic rst,
  input logic advance,
  input logic restart,
  output logic [`TS_POS_W-1:0] pos,
  output logic last
);

  logic [`TS_POS_W-1:0] next_pos; // position of the next beat

  // a sync beat is always position 0
  assign pos = restart ? '0 : next_pos;
  assign last = (pos == `TS_PACKET_BYTES - 1);

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      next_pos <= '0;
    end else if (advance) begin
      next_pos <= last ? '0 : pos + 1'b1;
    end
  end

  a_pos_in_range: assert property (
    @(posedge axi_clk) disable iff (rst)
    pos < `TS_PACKET_BYTES
  );

endmodule

// ==== verilog/pid_match_if.sv ====
`timescale 1ns/10ps
`include "ts_filter_defines.svh"

interface pid_match_if;
  logic lookup;
  logic [12:0] live_pid;
  logic replace_hit;
  logic [`TS_SLOT_W-1:0] replace_slot;
  logic [`TS_FILTER_SLOTS-1:0] monitor_mask;

  // state machine asks, table answers in the same cycle
  modport fsm (
    output lookup,
    output live_pid,
    input replace_hit,
    input replace_slot,
    input monitor_mask
  );

  modport tbl (
    input lookup,
    input live_pid,
    output replace_hit,
    output replace_slot,
    output monitor_mask
  );
endinterface

// ==== verilog/ts_filter_pkg.sv ====
package ts_filter_pkg;

  // 4-byte TS header, seen either as raw bytes or as fields
  typedef union packed {
    logic [0:3][7:0] bytes; // bytes[0] arrives first
    struct packed {
      logic [7:0] sync;
      logic err;
      logic pusi;       // payload unit start
      logic prio;
      logic [12:0] pid;
      logic [1:0] scramble;
      logic [1:0] adapt;
      logic [3:0] cc;
    } fields;
  } ts_header_t;

endpackage

// ==== verilog/ts_filter_defines.svh ====
`ifndef TS_FILTER_DEFINES_SVH
`define TS_FILTER_DEFINES_SVH

// transport packet geometry
`define TS_PACKET_BYTES 188
`define TS_HEADER_BYTES 4

// first byte of every packet
`define TS_SYNC_BYTE 8'h47

// replace and monitor tables have the same depth
`define TS_FILTER_SLOTS 8
`define TS_SLOT_W 3

// byte position inside a packet, 0..187
`define TS_POS_W 8

`endif
